/* files.f */
ahb_pkg.sv
boot_pkg.sv
xfer_if.sv
ahb_xfer_engine.sv
boot_sequencer.sv
nvm_boot_copier.sv
tb_ahb_slave_model.sv
tb_nvm_boot_copier.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_nvm_boot_copier -f files.f -o sim_tb

output=$(./obj_dir/sim_tb) || true
echo "$output"

if echo "$output" | grep -q "Simulation passed"; then
	exit 0
else
	exit 1
fi

/* tb_nvm_boot_copier.sv */
// testbench top with clock, reset, stimulus, bus monitor, transfer checks, assertions and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_nvm_boot_copier import ahb_pkg::*, boot_pkg::*; ();

	// worst case is near 90 cycles per word, so 128 words fit with margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int IDLE_CYCLES    = 10;

	typedef enum {S_REQ, S_GRANT, S_POLL, S_READ, S_WRITE, S_REL, S_END} stage_e;

	logic        HCLK;
	logic        HRESETn;
	logic        start;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [2:0]  HBURST;
	logic [3:0]  HPROT;
	logic [31:0] HWDATA;
	logic [31:0] HRDATA;
	logic        HREADY;
	logic        ahb_busy;
	logic        ram_init_done;

	stage_e      stage     = S_REQ;	// next transfer expected
	int          req_count = 0;
	int          word_idx  = 0;
	int          byte_idx  = 0;
	int          cycles    = 0;
	logic        in_dp     = 1'b0;
	logic        ap_stall  = 1'b0;	// previous address phase cycle had HREADY low
	logic        dp_stall  = 1'b0;
	logic [31:0] a_addr    = '0;
	logic        a_write   = 1'b0;
	logic [2:0]  a_size    = '0;
	logic [31:0] d_wdata   = '0;

	nvm_boot_copier u_dut
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.start         (start),
		.HADDR         (HADDR),
		.HTRANS        (HTRANS),
		.HWRITE        (HWRITE),
		.HSIZE         (HSIZE),
		.HBURST        (HBURST),
		.HPROT         (HPROT),
		.HWDATA        (HWDATA),
		.HRDATA        (HRDATA),
		.HREADY        (HREADY),
		.ahb_busy      (ahb_busy),
		.ram_init_done (ram_init_done)
	);

	tb_ahb_slave_model u_slave
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.HADDR   (HADDR),
		.HTRANS  (HTRANS),
		.HWRITE  (HWRITE),
		.HWDATA  (HWDATA),
		.HRDATA  (HRDATA),
		.HREADY  (HREADY)
	);

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
			fail_now($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	// compare one finished transfer with the next step of the boot sequence
	task automatic check_transfer(input logic [31:0] rdata);
		logic [31:0] exp_addr;
		logic        exp_write;
		logic [2:0]  exp_size;
		logic [31:0] exp_wdata;
		logic [31:0] mask;
		logic [31:0] word;
		exp_addr  = NVM_CTRL_ADDR;
		exp_write = 1'b0;
		exp_size  = HSIZE_WORD;
		exp_wdata = '0;
		mask      = 32'hFFFF_FFFF;
		case (stage)
			S_REQ:
			begin
				exp_write = 1'b1;
				exp_wdata = ACCESS_REQ;
				req_count++;
				stage = S_GRANT;
			end
			S_GRANT:
				stage = (rdata[2:0] == GRANT_CODE) ? S_POLL : S_REQ;
			S_POLL:
			begin
				exp_addr = NVM_STATUS_ADDR;
				if (rdata[READY_BIT])
					stage = S_READ;
			end
			S_READ:
			begin
				exp_addr = NVM_BASE + 32'(4 * word_idx);
				stage    = S_WRITE;
			end
			S_WRITE:
			begin
				word      = u_slave.flash_mem[word_idx];
				exp_addr  = RAM_BASE + 32'(16 * word_idx + 4 * byte_idx);
				exp_write = 1'b1;
				exp_size  = HSIZE_BYTE;
				exp_wdata = 32'(word[8*byte_idx +: 8]);
				mask      = 32'h0000_00FF;	// lane 0
				byte_idx++;
				if (byte_idx == 4)
				begin
					byte_idx = 0;
					word_idx++;
					stage = (word_idx == COPY_WORDS) ? S_REL : S_POLL;
				end
			end
			S_REL:
			begin
				exp_write = 1'b1;
				exp_wdata = ACCESS_REL;
				stage     = S_END;
			end
			default:
				fail_now("a bus transfer started after flash access was released");
		endcase
		check_value("HADDR", exp_addr, a_addr);
		check_value("HWRITE", 32'(exp_write), 32'(a_write));
		check_value("HSIZE", 32'(exp_size), 32'(a_size));
		if (exp_write)
			check_value("HWDATA", exp_wdata & mask, d_wdata & mask);
	endtask

	initial
	begin
		HCLK = 1'b0;
		forever #50 HCLK = ~HCLK;
	end

	always @(posedge HCLK)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			fail_now("timeout, the boot copy did not finish in time");
	end

	// bus monitor sampling at the falling edge where all bus signals are stable
	always @(negedge HCLK)
	begin
		if (HRESETn)
		begin
			if (in_dp)
			begin
				if (dp_stall && a_write)
					check_value("HWDATA", d_wdata, HWDATA);
				d_wdata  = HWDATA;
				dp_stall = !HREADY;
				if (HREADY)
				begin
					in_dp = 1'b0;
					check_transfer(HRDATA);
				end
			end
			if (HTRANS == HTRANS_NONSEQ)
			begin
				if (ap_stall)
				begin
					check_value("HADDR", a_addr, HADDR);
					check_value("HWRITE", 32'(a_write), 32'(HWRITE));
					check_value("HSIZE", 32'(a_size), 32'(HSIZE));
				end
				a_addr   = HADDR;
				a_write  = HWRITE;
				a_size   = HSIZE;
				ap_stall = !HREADY;
				if (HREADY)
				begin
					in_dp    = 1'b1;
					dp_stall = 1'b0;
				end
			end
			else if (ap_stall)
				fail_now("HTRANS left NONSEQ during a stalled address phase");
		end
	end

	a_hburst: assert property (@(posedge HCLK) HBURST == HBURST_SINGLE)
		else fail_now($sformatf("Fail at %0t: HBURST expected %h, got %h",
			$time, HBURST_SINGLE, HBURST));

	a_hprot: assert property (@(posedge HCLK) HPROT == HPROT_DATA)
		else fail_now($sformatf("Fail at %0t: HPROT expected %h, got %h",
			$time, HPROT_DATA, HPROT));

	a_quiet_after_done: assert property (@(posedge HCLK) disable iff (!HRESETn)
		ram_init_done |-> (HTRANS == HTRANS_IDLE && !ahb_busy))
		else fail_now("bus activity or ahb_busy seen after ram_init_done");

	a_done_holds: assert property (@(posedge HCLK) disable iff (!HRESETn)
		ram_init_done |=> ram_init_done)
		else fail_now("ram_init_done fell after it had risen");

	initial
	begin
		int w;
		int b;
		HRESETn = 1'b0;
		start   = 1'b0;
		repeat (3) @(posedge HCLK);
		#1 HRESETn = 1'b1;
		repeat (IDLE_CYCLES)
		begin
			@(negedge HCLK);
			check_value("HTRANS", 32'(HTRANS_IDLE), 32'(HTRANS));
			check_value("ahb_busy", 32'd0, 32'(ahb_busy));
			check_value("ram_init_done", 32'd0, 32'(ram_init_done));
		end
		@(posedge HCLK);
		#1 start = 1'b1;	// stays high for the rest of the run
		@(posedge HCLK);
		@(negedge HCLK);
		while (!ram_init_done)
		begin
			check_value("ahb_busy", 32'd1, 32'(ahb_busy));	// high for the whole copy
			@(negedge HCLK);
		end
		check_value("ahb_busy", 32'd0, 32'(ahb_busy));
		check_value("copy stage", 32'(S_END), 32'(stage));
		check_value("access requests", 32'd3, 32'(req_count));
		check_value("words copied", COPY_WORDS, 32'(word_idx));
		repeat (20)
		begin
			@(negedge HCLK);
			check_value("HTRANS", 32'(HTRANS_IDLE), 32'(HTRANS));
		end
		for (w = 0; w < COPY_WORDS; w++)
			for (b = 0; b < 4; b++)
				check_value($sformatf("sram slot %0d", 4 * w + b),
					32'(u_slave.flash_mem[w][8*b +: 8]), 32'(u_slave.sram_mem[4*w+b]));
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_ahb_slave_model.sv */
// testbench AHB-Lite slave with flash image, flash control and status registers, SRAM and random wait states
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_slave_model import ahb_pkg::*, boot_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADY
);

	logic [15:0] lfsr;
	logic [31:0] flash_mem [COPY_WORDS];
	logic [7:0]  sram_mem [4*COPY_WORDS];	// one byte per word-aligned slot
	int          ctrl_reads;
	int          not_ready_left;	// status polls still answered not-ready
	int          wait_left;	// HREADY low cycles left in this phase
	logic        in_addr;
	logic        in_data;
	logic        fresh;	// data phase begins at the coming edge
	logic [31:0] d_addr;
	logic        d_write;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16 + x^14 + x^13 + x^11
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] read_data(input logic [31:0] addr);
		logic [31:0] v;
		v = '0;
		if (addr == NVM_CTRL_ADDR)
		begin
			if (ctrl_reads >= 2)	// first two readbacks deny access
				v = 32'(GRANT_CODE);
			ctrl_reads++;
		end
		else if (addr == NVM_STATUS_ADDR)
		begin
			if (not_ready_left == 0)
			begin
				v[READY_BIT]   = 1'b1;
				not_ready_left = int'(take_bits(2));	// busy polls before the next word
			end
			else
				not_ready_left--;
		end
		else if (addr >= NVM_BASE && addr < NVM_BASE + 32'(4 * COPY_WORDS))
			v = flash_mem[int'((addr - NVM_BASE) >> 2)];
		return v;
	endfunction

	initial
	begin
		int i;
		lfsr       = 16'd43132;
		HREADY     = 1'b1;
		HRDATA     = '0;
		ctrl_reads = 0;
		wait_left  = 0;
		in_addr    = 1'b0;
		in_data    = 1'b0;
		fresh      = 1'b0;
		d_addr     = '0;
		d_write    = 1'b0;
		for (i = 0; i < COPY_WORDS; i++)
			flash_mem[i] = take_bits(32);
		not_ready_left = int'(take_bits(2));
		forever
		begin
			@(negedge HCLK);	// decide what the coming edge completes
			if (HRESETn)
			begin
				fresh = 1'b0;
				if (HREADY && in_data)
				begin
					in_data = 1'b0;
					if (d_write && d_addr >= RAM_BASE && d_addr < RAM_BASE + 32'(16 * COPY_WORDS))
						sram_mem[int'((d_addr - RAM_BASE) >> 2)] = HWDATA[7:0];
				end
				if (HREADY && HTRANS == HTRANS_NONSEQ)
				begin
					in_addr   = 1'b0;
					in_data   = 1'b1;
					fresh     = 1'b1;
					d_addr    = HADDR;
					d_write   = HWRITE;
					wait_left = int'(take_bits(2));
				end
				@(posedge HCLK);
				#1;
				if (!in_addr && !in_data && HTRANS == HTRANS_NONSEQ)
				begin
					in_addr   = 1'b1;	// new address phase seen
					wait_left = int'(take_bits(2));
				end
				if (fresh && !d_write)
					HRDATA = read_data(d_addr);
				HREADY = (wait_left == 0);
				if (wait_left != 0)
					wait_left--;
			end
		end
	end

endmodule

`default_nettype wire

/* nvm_boot_copier.sv */
// top level of the flash-to-SRAM boot copier with AHB-Lite master ports
`timescale 1ns/1ps
`default_nettype none

module nvm_boot_copier import ahb_pkg::*;
(
	input  logic              HCLK,
	input  logic              HRESETn,
	input  logic              start,
	output logic [ADDR_W-1:0] HADDR,
	output logic [1:0]        HTRANS,
	output logic              HWRITE,
	output logic [2:0]        HSIZE,
	output logic [2:0]        HBURST,
	output logic [3:0]        HPROT,
	output logic [DATA_W-1:0] HWDATA,
	input  logic [DATA_W-1:0] HRDATA,
	input  logic              HREADY,
	output logic              ahb_busy,
	output logic              ram_init_done
);

	xfer_if u_xfer ();

	assign HBURST = HBURST_SINGLE;	// never bursts
	assign HPROT  = HPROT_DATA;

	boot_sequencer u_seq
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.start         (start),
		.xfer          (u_xfer.seq),
		.ahb_busy      (ahb_busy),
		.ram_init_done (ram_init_done)
	);

	ahb_xfer_engine u_eng
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.bus     (u_xfer.eng),
		.HADDR   (HADDR),
		.HTRANS  (HTRANS),
		.HWRITE  (HWRITE),
		.HSIZE   (HSIZE),
		.HWDATA  (HWDATA),
		.HRDATA  (HRDATA),
		.HREADY  (HREADY)
	);

endmodule

`default_nettype wire

/* boot_sequencer.sv */
// boot copy FSM: flash access request and grant, ready polling, word reads, byte writes, release
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer import ahb_pkg::*, boot_pkg::*;
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic start,
	xfer_if.seq  xfer,
	output logic ahb_busy,
	output logic ram_init_done
);

	boot_state_e           state;
	logic                  issue;	// start pulse to the engine
	logic [ADDR_W-1:0]     nvm_addr;
	logic [ADDR_W-1:0]     ram_addr;
	logic [WORD_CNT_W-1:0] word_cnt;	// words already copied
	logic [1:0]            byte_idx;	// byte of word_buf being written
	logic [DATA_W-1:0]     word_buf;

	logic [ADDR_W-1:0]     cmd_addr;
	logic                  cmd_write;
	logic [DATA_W-1:0]     cmd_wdata;
	hsize_e                cmd_size;

	// command follows the state, the engine samples it on the start pulse
	always_comb
	begin
		cmd_addr  = NVM_CTRL_ADDR;
		cmd_write = 1'b0;
		cmd_wdata = '0;
		cmd_size  = HSIZE_WORD;
		case (state)
			ST_REQ:
			begin
				cmd_write = 1'b1;
				cmd_wdata = ACCESS_REQ;
			end
			ST_POLL:
				cmd_addr = NVM_STATUS_ADDR;
			ST_READ:
				cmd_addr = nvm_addr;
			ST_WRITE:
			begin
				cmd_addr  = ram_addr;
				cmd_write = 1'b1;
				cmd_wdata = DATA_W'(word_buf[{byte_idx, 3'b000} +: 8]);	// lane 0 only
				cmd_size  = HSIZE_BYTE;
			end
			ST_RELEASE:
			begin
				cmd_write = 1'b1;
				cmd_wdata = ACCESS_REL;
			end
			default:
			begin
				cmd_addr = NVM_CTRL_ADDR;	// grant readback and idle states
			end
		endcase
	end

	assign xfer.start = issue;
	assign xfer.write = cmd_write;
	assign xfer.addr  = cmd_addr;
	assign xfer.wdata = cmd_wdata;
	assign xfer.size  = cmd_size;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			state         <= ST_IDLE;
			issue         <= 1'b0;
			nvm_addr      <= NVM_BASE;
			ram_addr      <= RAM_BASE;
			word_cnt      <= '0;
			byte_idx      <= '0;
			ahb_busy      <= 1'b0;
			ram_init_done <= 1'b0;
		end
		else
		begin
			issue <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state    <= ST_REQ;
						issue    <= 1'b1;
						ahb_busy <= 1'b1;
					end
				end
				ST_REQ:
				begin
					if (xfer.done)
					begin
						state <= ST_GRANT;
						issue <= 1'b1;
					end
				end
				ST_GRANT:
				begin
					if (xfer.done)
					begin
						issue <= 1'b1;
						if (xfer.rdata[2:0] == GRANT_CODE)
							state <= ST_POLL;
						else
							state <= ST_REQ;	// denied, ask again
					end
				end
				ST_POLL:
				begin
					if (xfer.done)
					begin
						issue <= 1'b1;
						if (xfer.rdata[READY_BIT])
							state <= ST_READ;
					end
				end
				ST_READ:
				begin
					if (xfer.done)
					begin
						state    <= ST_WRITE;
						issue    <= 1'b1;
						byte_idx <= '0;
					end
				end
				ST_WRITE:
				begin
					if (xfer.done)
					begin
						ram_addr <= ram_addr + 32'd4;	// one byte per SRAM slot
						if (byte_idx == 2'd3)
							state <= ST_NEXT;
						else
						begin
							byte_idx <= byte_idx + 2'd1;
							issue    <= 1'b1;
						end
					end
				end
				ST_NEXT:
				begin
					issue <= 1'b1;
					if (word_cnt == WORD_CNT_W'(COPY_WORDS - 1))
						state <= ST_RELEASE;
					else
					begin
						word_cnt <= word_cnt + 1'b1;
						nvm_addr <= nvm_addr + 32'd4;
						state    <= ST_POLL;
					end
				end
				ST_RELEASE:
				begin
					if (xfer.done)
					begin
						state         <= ST_DONE;
						ahb_busy      <= 1'b0;
						ram_init_done <= 1'b1;
					end
				end
				default:
					state <= ST_DONE;	// stays here until reset
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (state == ST_READ && xfer.done)
			word_buf <= xfer.rdata;
	end

	// byte writes land on word-aligned slots
	a_ram_align: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(xfer.start && xfer.size == HSIZE_BYTE) |-> (xfer.addr[1:0] == 2'b00));

	a_done_sticky: assert property (@(posedge HCLK) disable iff (!HRESETn)
		ram_init_done |=> ram_init_done);

endmodule

`default_nettype wire

/* ahb_xfer_engine.sv */
// AHB-Lite master engine running one single transfer at a time with wait states
`timescale 1ns/1ps
`default_nettype none

module ahb_xfer_engine import ahb_pkg::*;
(
	input  logic              HCLK,
	input  logic              HRESETn,
	xfer_if.eng               bus,
	output logic [ADDR_W-1:0] HADDR,
	output htrans_e           HTRANS,
	output logic              HWRITE,
	output hsize_e            HSIZE,
	output logic [DATA_W-1:0] HWDATA,
	input  logic [DATA_W-1:0] HRDATA,
	input  logic              HREADY
);

	typedef enum logic [1:0]
	{
		E_IDLE = 2'd0,
		E_ADDR = 2'd1,	// NONSEQ on the bus
		E_DATA = 2'd2	// HWDATA out or read data expected
	} eng_state_e;

	eng_state_e        state;
	logic              done_q;
	logic [DATA_W-1:0] wdata_q;	// write data held until data phase
	logic [DATA_W-1:0] rdata_q;

	assign bus.busy  = (state != E_IDLE);
	assign bus.done  = done_q;
	assign bus.rdata = rdata_q;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			state  <= E_IDLE;
			HADDR  <= '0;
			HTRANS <= HTRANS_IDLE;
			HWRITE <= 1'b0;
			HSIZE  <= HSIZE_WORD;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				E_IDLE:
				begin
					if (bus.start)
					begin
						HADDR  <= bus.addr;	// address phase starts next cycle
						HWRITE <= bus.write;
						HSIZE  <= bus.size;
						HTRANS <= HTRANS_NONSEQ;
						state  <= E_ADDR;
					end
				end
				E_ADDR:
				begin
					if (HREADY)
					begin
						HTRANS <= HTRANS_IDLE;	// no follow-on transfer
						state  <= E_DATA;
					end
				end
				E_DATA:
				begin
					if (HREADY)
					begin
						done_q <= 1'b1;
						state  <= E_IDLE;
					end
				end
				default:
					state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (state == E_IDLE && bus.start)
			wdata_q <= bus.wdata;
		if (state == E_ADDR && HREADY)
			HWDATA <= wdata_q;	// held through data phase stalls
		if (state == E_DATA && HREADY && !HWRITE)
			rdata_q <= HRDATA;
	end

	// slave stall must not see the address phase change under it
	a_addr_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(state == E_ADDR && !HREADY) |=>
		($stable(HADDR) && $stable(HWRITE) && $stable(HSIZE) && HTRANS == HTRANS_NONSEQ));

	// the sequencer keeps only one transfer in flight
	a_no_overlap: assert property (@(posedge HCLK) disable iff (!HRESETn)
		bus.start |-> !bus.busy);

endmodule

`default_nettype wire

/* xfer_if.sv */
// single-transfer command and result channel between the boot sequencer and the AHB engine
`timescale 1ns/1ps
`default_nettype none

interface xfer_if import ahb_pkg::*; ();

	// command, valid on the start cycle
	logic              start;	// one cycle pulse
	logic              write;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	hsize_e            size;

	// result
	logic              busy;	// transfer in progress
	logic              done;	// one cycle pulse after data phase
	logic [DATA_W-1:0] rdata;	// valid with done on reads

	modport seq
	(
		output start, write, addr, wdata, size,
		input  busy, done, rdata
	);

	modport eng
	(
		input  start, write, addr, wdata, size,
		output busy, done, rdata
	);

endinterface

`default_nettype wire

/* boot_pkg.sv */
// flash and SRAM memory map, access codes, copy length and the sequencer state type
`default_nettype none

package boot_pkg;

	// memory map
	localparam logic [31:0] NVM_BASE        = 32'h6000_0800;	// first flash word
	localparam logic [31:0] NVM_CTRL_ADDR   = 32'h6008_01FC;	// fabric access control
	localparam logic [31:0] NVM_STATUS_ADDR = 32'h6008_0120;	// flash status
	localparam logic [31:0] RAM_BASE        = 32'h1000_0000;	// first SRAM slot

	// control register values
	localparam logic [31:0] ACCESS_REQ = 32'h0000_0001;	// request fabric access
	localparam logic [31:0] ACCESS_REL = 32'h0000_0000;	// hand access back
	localparam logic [2:0]  GRANT_CODE = 3'b110;	// readback bits 2:0 when granted

	localparam int unsigned READY_BIT = 0;	// status word ready flag

	// 128 words fill 512 byte slots in SRAM
	localparam int unsigned COPY_WORDS = 128;
	localparam int unsigned WORD_CNT_W = $clog2(COPY_WORDS);

	typedef enum logic [3:0]
	{
		ST_IDLE    = 4'd0,	// wait for start
		ST_REQ     = 4'd1,	// write access request
		ST_GRANT   = 4'd2,	// read back control and check grant
		ST_POLL    = 4'd3,	// read status until ready
		ST_READ    = 4'd4,	// read one flash word
		ST_WRITE   = 4'd5,	// one byte to SRAM
		ST_NEXT    = 4'd6,	// next word or release
		ST_RELEASE = 4'd7,	// write access release
		ST_DONE    = 4'd8	// terminal
	} boot_state_e;

endpackage

`default_nettype wire

/* ahb_pkg.sv */
// AHB-Lite transfer type, size and burst encodings, protection value and bus widths
`default_nettype none

package ahb_pkg;

	localparam int unsigned ADDR_W = 32;	// address bus width
	localparam int unsigned DATA_W = 32;	// data bus width

	// HTRANS codes, only single transfers are issued
	typedef enum logic [1:0]
	{
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10
	} htrans_e;

	// HSIZE codes in use
	typedef enum logic [2:0]
	{
		HSIZE_BYTE = 3'b000,	// 8 bit
		HSIZE_WORD = 3'b010	// 32 bit
	} hsize_e;

	localparam logic [2:0] HBURST_SINGLE = 3'b000;	// single transfer burst

	// privileged data access, not cacheable, not bufferable
	localparam logic [3:0] HPROT_DATA = 4'b0011;

endpackage

`default_nettype wire
